// File: gpr_pkg.sv
package gpr_pkg;

    // architectural sizes of the integer register file
    // eight registers, fixed by the x86 register model
    localparam int num_regs = 8;

    // full register width in bits
    localparam int data_width = 32;

    // width of a register id, enough for eax through edi
    localparam int reg_id_width = 3;

    // operand size code, as carried on the write and read ports
    // encoding matches the size field the decoder was built around
    typedef enum logic [1:0] {
        // byte access, al..bl for id 0-3, ah..bh for id 4-7
        size_8    = 2'd0,
        // word access, bits 15:0
        size_16   = 2'd1,
        // doubleword access, whole register
        size_32   = 2'd2,
        // reserved, writes are dropped and reads return zero
        size_rsvd = 2'd3
    } op_size_e;

    // whole bank contents
    // index 0 is eax, 1 ecx, 2 edx, 3 ebx, 4 esp, 5 ebp, 6 esi, 7 edi
    typedef logic [num_regs-1:0][data_width-1:0] reg_array_t;

endpackage

// File: gpr_lane_if.sv
`timescale 1ns/100ps

interface gpr_lane_if;

    // per-register byte enables, bit n belongs to register n
    // hh is bits 31:24, hl 23:16, lh 15:8, ll 7:0
    logic [gpr_pkg::num_regs-1:0]   wr_hh;
    logic [gpr_pkg::num_regs-1:0]   wr_hl;
    logic [gpr_pkg::num_regs-1:0]   wr_lh;
    logic [gpr_pkg::num_regs-1:0]   wr_ll;

    // write data already moved onto its byte lanes
    logic [gpr_pkg::data_width-1:0] lane_data;

    // decoder side produces enables and aligned data
    modport decoder (output wr_hh, wr_hl, wr_lh, wr_ll, lane_data);

    // register bank only consumes them
    modport bank (input wr_hh, wr_hl, wr_lh, wr_ll, lane_data);

endinterface

// File: reg_write_decoder.sv
`timescale 1ns/100ps

module reg_write_decoder (
    // write strobe, one write per cycle when high
    input  logic                              write_en,
    // architectural id as seen by the instruction
    input  logic [gpr_pkg::reg_id_width-1:0]  write_id,
    input  gpr_pkg::op_size_e                 write_size,
    // operand, right aligned whatever the size
    input  logic [gpr_pkg::data_width-1:0]    write_data,
    gpr_lane_if.decoder                       lanes
);

    // set for ah, ch, dh, bh
    logic                             high_byte;
    // physical register that receives the write
    logic [gpr_pkg::reg_id_width-1:0] target_id;
    // lanes touched inside the target, order hh hl lh ll
    logic [3:0]                       lane_mask;
    // one-hot register select, already gated by write_en
    logic [gpr_pkg::num_regs-1:0]     reg_sel;

    always_comb begin
        // byte writes with id 4-7 land in bits 15:8 of id minus 4
        high_byte = (write_size == gpr_pkg::size_8) && write_id[gpr_pkg::reg_id_width-1];
        if (high_byte) begin
            target_id = {1'b0, write_id[gpr_pkg::reg_id_width-2:0]};
        end else begin
            target_id = write_id;
        end
    end

    always_comb begin
        // lane pattern per operand size
        case (write_size)
            gpr_pkg::size_32: lane_mask = 4'b1111;
            gpr_pkg::size_16: lane_mask = 4'b0011;
            gpr_pkg::size_8: begin
                if (high_byte) begin
                    lane_mask = 4'b0010;
                end else begin
                    lane_mask = 4'b0001;
                end
            end
            // reserved size writes nothing
            default: lane_mask = 4'b0000;
        endcase
    end

    always_comb begin
        reg_sel            = '0;
        reg_sel[target_id] = write_en;
    end

    // enables are the register select masked per lane
    assign lanes.wr_hh = reg_sel & {gpr_pkg::num_regs{lane_mask[3]}};
    assign lanes.wr_hl = reg_sel & {gpr_pkg::num_regs{lane_mask[2]}};
    assign lanes.wr_lh = reg_sel & {gpr_pkg::num_regs{lane_mask[1]}};
    assign lanes.wr_ll = reg_sel & {gpr_pkg::num_regs{lane_mask[0]}};

    // upper lanes pass straight through
    // lane 1 takes the low byte for ah..bh so it lands in bits 15:8
    assign lanes.lane_data[gpr_pkg::data_width-1:16] = write_data[gpr_pkg::data_width-1:16];
    assign lanes.lane_data[15:8] = high_byte ? write_data[7:0] : write_data[15:8];
    assign lanes.lane_data[7:0]  = write_data[7:0];

endmodule

// File: gpr_bank.sv
`timescale 1ns/100ps

module gpr_bank (
    input  logic                clk,
    input  logic                reset,
    // byte enables and aligned data from the write decoder
    gpr_lane_if.bank            lanes,
    // full contents, always visible to the read ports
    output gpr_pkg::reg_array_t regs
);

    // byte lanes in one register
    localparam int lanes_per_reg = gpr_pkg::data_width / 8;

    // enables regrouped per register, bit b covers bits 8b+7:8b
    logic [gpr_pkg::num_regs-1:0][lanes_per_reg-1:0] byte_en;

    always_comb begin
        for (int r = 0; r < gpr_pkg::num_regs; r++) begin
            byte_en[r] = {lanes.wr_hh[r], lanes.wr_hl[r], lanes.wr_lh[r], lanes.wr_ll[r]};
        end
    end

    // one write edge, new value seen by the reads right after it
    // a read in the same cycle still sees the old contents
    always_ff @(posedge clk) begin
        if (reset) begin
            // reset overrides any enable in flight
            regs <= '0;
        end else begin
            for (int r = 0; r < gpr_pkg::num_regs; r++) begin
                for (int b = 0; b < lanes_per_reg; b++) begin
                    // untouched bytes keep their value
                    if (byte_en[r][b]) begin
                        regs[r][b*8 +: 8] <= lanes.lane_data[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: gpr_read_port.sv
`timescale 1ns/100ps

module gpr_read_port (
    // bank contents, shared by all read ports
    input  gpr_pkg::reg_array_t               regs,
    input  logic [gpr_pkg::reg_id_width-1:0]  read_id,
    input  gpr_pkg::op_size_e                 read_size,
    // operand zero extended to full width
    output logic [gpr_pkg::data_width-1:0]    read_data
);

    // set for ah, ch, dh, bh
    logic                             high_byte;
    // physical register actually read
    logic [gpr_pkg::reg_id_width-1:0] sel_id;
    // whole selected register before sizing
    logic [gpr_pkg::data_width-1:0]   word;

    always_comb begin
        // same aliasing rule as the write side
        high_byte = (read_size == gpr_pkg::size_8) && read_id[gpr_pkg::reg_id_width-1];
        if (high_byte) begin
            sel_id = {1'b0, read_id[gpr_pkg::reg_id_width-2:0]};
        end else begin
            sel_id = read_id;
        end
        word = regs[sel_id];
    end

    always_comb begin
        case (read_size)
            gpr_pkg::size_32: read_data = word;
            // ax..di
            gpr_pkg::size_16: read_data = {{(gpr_pkg::data_width-16){1'b0}}, word[15:0]};
            gpr_pkg::size_8: begin
                if (high_byte) begin
                    // ah..bh come down to bits 7:0
                    read_data = {{(gpr_pkg::data_width-8){1'b0}}, word[15:8]};
                end else begin
                    read_data = {{(gpr_pkg::data_width-8){1'b0}}, word[7:0]};
                end
            end
            // reserved size reads as zero
            default: read_data = '0;
        endcase
    end

endmodule

// File: gpr_file.sv
`timescale 1ns/100ps

module gpr_file (
    input  logic                              clk,
    // synchronous, clears all eight registers
    input  logic                              reset,

    // write port, taken on every edge the strobe is high
    input  logic                              write_en,
    input  logic [gpr_pkg::reg_id_width-1:0]  write_id,
    input  gpr_pkg::op_size_e                 write_size,
    input  logic [gpr_pkg::data_width-1:0]    write_data,

    // read port a, combinational
    input  logic [gpr_pkg::reg_id_width-1:0]  rd_a_id,
    input  gpr_pkg::op_size_e                 rd_a_size,
    output logic [gpr_pkg::data_width-1:0]    rd_a_data,

    // read port b, combinational
    input  logic [gpr_pkg::reg_id_width-1:0]  rd_b_id,
    input  gpr_pkg::op_size_e                 rd_b_size,
    output logic [gpr_pkg::data_width-1:0]    rd_b_data
);

    // byte lane enables and aligned data, decoder to bank
    gpr_lane_if lanes ();

    // current bank contents fanned out to both readers
    gpr_pkg::reg_array_t regs;

    // size and id to byte lanes
    reg_write_decoder u_decoder (
        .write_en   (write_en),
        .write_id   (write_id),
        .write_size (write_size),
        .write_data (write_data),
        .lanes      (lanes)
    );

    // storage
    gpr_bank u_bank (
        .clk   (clk),
        .reset (reset),
        .lanes (lanes),
        .regs  (regs)
    );

    // source operand a
    gpr_read_port port_a (
        .regs      (regs),
        .read_id   (rd_a_id),
        .read_size (rd_a_size),
        .read_data (rd_a_data)
    );

    // source operand b
    gpr_read_port port_b (
        .regs      (regs),
        .read_id   (rd_b_id),
        .read_size (rd_b_size),
        .read_data (rd_b_data)
    );

endmodule

// File: tb_gpr_file.sv
`timescale 1ns/100ps

module tb_gpr_file;

    logic                clk = 1'b0;
    logic                reset;
    logic                write_en;
    logic [2:0]          write_id;
    gpr_pkg::op_size_e   write_size;
    logic [31:0]         write_data;
    logic [2:0]          rd_a_id;
    gpr_pkg::op_size_e   rd_a_size;
    logic [31:0]         rd_a_data;
    logic [2:0]          rd_b_id;
    gpr_pkg::op_size_e   rd_b_size;
    logic [31:0]         rd_b_data;

    // reference copy of eax..edi
    logic [31:0] model [0:7];

    gpr_file UUT (
        .clk        (clk),
        .reset      (reset),
        .write_en   (write_en),
        .write_id   (write_id),
        .write_size (write_size),
        .write_data (write_data),
        .rd_a_id    (rd_a_id),
        .rd_a_size  (rd_a_size),
        .rd_a_data  (rd_a_data),
        .rd_b_id    (rd_b_id),
        .rd_b_size  (rd_b_size),
        .rd_b_data  (rd_b_data)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // x86 sizing on the write side
    // ah..bh alias bits 15:8 of id minus 4
    function automatic void apply_write(input logic [2:0] id, input gpr_pkg::op_size_e size,
                                        input logic [31:0] data);
        case (size)
            gpr_pkg::size_32: model[id] = data;
            gpr_pkg::size_16: model[id][15:0] = data[15:0];
            gpr_pkg::size_8: begin
                if (id < 3'd4) begin
                    model[id][7:0] = data[7:0];
                end else begin
                    model[id - 3'd4][15:8] = data[7:0];
                end
            end
            // reserved size is dropped
            default: ;
        endcase
    endfunction

    // sized read with zero extension
    // reserved size reads as zero
    function automatic logic [31:0] expected_read(input logic [2:0] id,
                                                  input gpr_pkg::op_size_e size);
        case (size)
            gpr_pkg::size_32: return model[id];
            gpr_pkg::size_16: return {16'h0000, model[id][15:0]};
            gpr_pkg::size_8: begin
                if (id < 3'd4) begin
                    return {24'h000000, model[id][7:0]};
                end
                return {24'h000000, model[id - 3'd4][15:8]};
            end
            default: return 32'h0000_0000;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("[FAIL] time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // one cycle of stimulus applied just after the rising edge
    task automatic drive_cycle(input logic we, input logic [2:0] wid,
                               input gpr_pkg::op_size_e wsize, input logic [31:0] wdata,
                               input logic [2:0] a_id, input gpr_pkg::op_size_e a_size,
                               input logic [2:0] b_id, input gpr_pkg::op_size_e b_size);
        @(posedge clk);
        #2;
        write_en   = we;
        write_id   = wid;
        write_size = wsize;
        write_data = wdata;
        rd_a_id    = a_id;
        rd_a_size  = a_size;
        rd_b_id    = b_id;
        rd_b_size  = b_size;
    endtask

    // model follows the dut on every rising edge
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                model[i] = 32'h0000_0000;
            end
        end else if (write_en) begin
            apply_write(write_id, write_size, write_data);
        end
    end

    // read ports are compared mid cycle where inputs and regs are settled
    initial begin
        int reset_cycles;
        reset_cycles = 0;
        forever begin
            @(negedge clk);
            if (reset !== 1'b0) begin
                reset_cycles++;
                if (reset_cycles > 20) begin
                    $display("reset was not released within 20 cycles");
                    $display("SIMULATION FAILED");
                    $fatal(1);
                end
            end else begin
                check_value("rd_a_data", rd_a_data, expected_read(rd_a_id, rd_a_size));
                check_value("rd_b_data", rd_b_data, expected_read(rd_b_id, rd_b_size));
            end
        end
    end

    initial begin
        logic [31:0]       r_ctl;
        logic [31:0]       r_data;
        logic [2:0]        a_id;
        gpr_pkg::op_size_e w_size;
        void'($urandom(56));
        reset      = 1'b1;
        write_en   = 1'b0;
        write_id   = 3'd0;
        write_size = gpr_pkg::size_32;
        write_data = 32'h0000_0000;
        rd_a_id    = 3'd0;
        rd_a_size  = gpr_pkg::size_32;
        rd_b_id    = 3'd0;
        rd_b_size  = gpr_pkg::size_32;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        // every register reads zero after reset
        for (int i = 0; i < 8; i++) begin
            drive_cycle(1'b0, 3'd0, gpr_pkg::size_32, 32'h0, 3'(i), gpr_pkg::size_32,
                        3'(7 - i), gpr_pkg::size_32);
        end

        // full word per id
        // the same cycle read still sees the old value
        for (int i = 0; i < 8; i++) begin
            drive_cycle(1'b1, 3'(i), gpr_pkg::size_32, 32'h3c5a_96f0 ^ (32'h0101_0101 * 32'(i + 1)),
                        3'(i), gpr_pkg::size_32, 3'(i), gpr_pkg::size_16);
            drive_cycle(1'b0, 3'd0, gpr_pkg::size_32, 32'h0, 3'(i), gpr_pkg::size_32,
                        3'(i), gpr_pkg::size_16);
            drive_cycle(1'b0, 3'd0, gpr_pkg::size_32, 32'h0, 3'(i), gpr_pkg::size_8,
                        3'(i), gpr_pkg::size_8);
        end

        // ah..bh writes
        // upper data bits must be ignored
        for (int i = 4; i < 8; i++) begin
            drive_cycle(1'b1, 3'(i), gpr_pkg::size_8, 32'hffff_ff00 | 32'(i * 17), 3'(i - 4),
                        gpr_pkg::size_32, 3'(i), gpr_pkg::size_8);
        end
        for (int i = 0; i < 4; i++) begin
            drive_cycle(1'b0, 3'd0, gpr_pkg::size_32, 32'h0, 3'(i), gpr_pkg::size_32,
                        3'(i + 4), gpr_pkg::size_8);
        end

        // word write to ebp then low byte write to dl
        drive_cycle(1'b1, 3'd5, gpr_pkg::size_16, 32'habcd_1234, 3'd5, gpr_pkg::size_32,
                    3'd2, gpr_pkg::size_32);
        drive_cycle(1'b1, 3'd2, gpr_pkg::size_8, 32'h1111_1177, 3'd5, gpr_pkg::size_32,
                    3'd2, gpr_pkg::size_32);
        drive_cycle(1'b0, 3'd0, gpr_pkg::size_32, 32'h0, 3'd5, gpr_pkg::size_32,
                    3'd2, gpr_pkg::size_32);

        // strobe low and then reserved size
        // neither may change anything
        drive_cycle(1'b0, 3'd0, gpr_pkg::size_32, 32'hdead_beef, 3'd0, gpr_pkg::size_32,
                    3'd1, gpr_pkg::size_32);
        drive_cycle(1'b1, 3'd1, gpr_pkg::size_rsvd, 32'hcafe_f00d, 3'd0, gpr_pkg::size_32,
                    3'd1, gpr_pkg::size_32);
        drive_cycle(1'b0, 3'd0, gpr_pkg::size_32, 32'h0, 3'd0, gpr_pkg::size_rsvd,
                    3'd1, gpr_pkg::size_rsvd);
        drive_cycle(1'b0, 3'd0, gpr_pkg::size_32, 32'h0, 3'd0, gpr_pkg::size_32,
                    3'd1, gpr_pkg::size_32);

        // mixed random traffic
        // port a is often aimed at the register being written
        for (int n = 0; n < 2000; n++) begin
            r_ctl  = $urandom;
            r_data = $urandom;
            w_size = gpr_pkg::op_size_e'(r_ctl[5:4]);
            a_id   = r_ctl[8:6];
            if (r_ctl[17:16] == 2'b00) begin
                a_id = r_ctl[3:1];
            end
            drive_cycle(r_ctl[0], r_ctl[3:1], w_size, r_data,
                        a_id, gpr_pkg::op_size_e'(r_ctl[10:9]),
                        r_ctl[13:11], gpr_pkg::op_size_e'(r_ctl[15:14]));
        end

        // let the last cycle be compared
        @(negedge clk);
        #1;
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: sim.f
gpr_pkg.sv
gpr_lane_if.sv
reg_write_decoder.sv
gpr_bank.sv
gpr_read_port.sv
gpr_file.sv
tb_gpr_file.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the register file testbench with verilator
# pass or fail is taken from the simulation log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
EXE=tb_gpr_file_sim

rm -rf "$OBJ" "$LOG"

verilator --binary --timing -f sim.f --top-module tb_gpr_file -Mdir "$OBJ" -o "$EXE"
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$OBJ/$EXE" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "result: fail"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if ! grep -q "SIMULATION PASSED" "$LOG"; then
    echo "no pass line found in $LOG"
    exit 1
fi

echo "result: pass"
exit 0
